// File: source/am_lock_defs.svh
`ifndef AM_LOCK_DEFS_SVH
`define AM_LOCK_DEFS_SVH

`default_nettype none

// physical lanes, same as the number of marker patterns
`define AM_N_LANES 4

// lane blocks from one marker to the next, short for simulation
`define AM_SPACING 32

`define AM_NB_LOCK_THR   3 // lock threshold input width
`define AM_NB_UNLOCK_THR 3 // unlock threshold input width

// logical lane number
`define AM_NB_LANE_ID 2

`default_nettype wire

`endif

// File: source/am_lock_pkg.sv
`include "am_lock_defs.svh"
`default_nettype none

package am_lock_pkg;

	// one 66b block on one lane
	typedef struct packed {
		logic        valid;
		logic [1:0]  sync;
		logic [63:0] payload;
	} lane_block_t;

	// per-lane report from the lock FSM
	typedef struct packed {
		logic                   am_lock;
		logic [`AM_N_LANES-1:0] match_mask;    // one bit per pattern
		logic                   start_of_lane;
		logic                   resync;
	} lane_status_t;

	localparam logic [1:0] sh_ctrl = 2'b10; // control block sync header

	// M0..M2 and M4..M6 compared, BIP bytes ignored
	localparam logic [63:0] am_cmp_mask = 64'hFFFFFF00_FFFFFF00;

	// marker patterns by logical lane, BIP fields left at zero
	localparam logic [63:0] am_table [`AM_N_LANES] = '{
		64'hC16821_00_3E97DE_00,
		64'h9D718E_00_628E71_00,
		64'h594BE8_00_A6B417_00,
		64'h4D957B_00_B26A84_00
	};

endpackage

`default_nettype wire

// File: source/block_distributor.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module block_distributor (
	input  wire                        i_clock,
	input  wire                        i_rst,
	input  wire am_lock_pkg::lane_block_t i_block,
	output am_lock_pkg::lane_block_t   o_lane_block [`AM_N_LANES]
);

	localparam int nb_turn = $clog2(`AM_N_LANES);

	logic [nb_turn-1:0]     turn;          // lane that takes the next block
	logic [`AM_N_LANES-1:0] lane_valid;
	logic [1:0]             lane_sync    [`AM_N_LANES];
	logic [63:0]            lane_payload [`AM_N_LANES];

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
			turn <= '0;
		else if (i_block.valid)
			turn <= (turn == nb_turn'(`AM_N_LANES - 1)) ? '0 : turn + 1'b1;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
			lane_valid <= '0;
		else
			for (int i = 0; i < `AM_N_LANES; i++)
				lane_valid[i] <= i_block.valid && (turn == nb_turn'(i));
	end

	// payload only loads on its own lane
	always_ff @(posedge i_clock)
	begin
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			if (i_block.valid && (turn == nb_turn'(i)))
			begin
				lane_sync[i]    <= i_block.sync;
				lane_payload[i] <= i_block.payload;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `AM_N_LANES; i++)
			o_lane_block[i] = '{valid: lane_valid[i], sync: lane_sync[i],
				payload: lane_payload[i]};
	end

	a_one_lane: assert property (@(posedge i_clock) disable iff (i_rst)
		$onehot0(lane_valid));

endmodule

`default_nettype wire

// File: source/am_detector.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module am_detector (
	input  wire                           i_clock,
	input  wire                           i_rst,
	input  wire am_lock_pkg::lane_block_t i_lane_block,
	input  wire [`AM_N_LANES-1:0]         i_match_mask,
	output logic                          o_block_valid,
	output logic                          o_am_valid,
	output logic [`AM_N_LANES-1:0]        o_match_vector
);

	import am_lock_pkg::*;

	logic                   is_ctrl;
	logic [`AM_N_LANES-1:0] hit;       // raw per-pattern compare
	logic [63:0]            payload_m; // BIP bytes cleared

	// markers only ride on control blocks
	assign is_ctrl   = i_lane_block.valid && (i_lane_block.sync == sh_ctrl);
	assign payload_m = i_lane_block.payload & am_cmp_mask;

	always_comb
	begin
		for (int i = 0; i < `AM_N_LANES; i++)
			hit[i] = is_ctrl && (payload_m == (am_table[i] & am_cmp_mask));
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			o_block_valid  <= 1'b0;
			o_am_valid     <= 1'b0;
			o_match_vector <= '0;
		end
		else
		begin
			o_block_valid  <= i_lane_block.valid;
			o_am_valid     <= |(hit & i_match_mask); // mask from the lock FSM
			o_match_vector <= hit;
		end
	end

	// the table patterns are distinct, so at most one can match
	a_single_hit: assert property (@(posedge i_clock) disable iff (i_rst)
		$onehot0(o_match_vector));

endmodule

`default_nettype wire

// File: source/am_lock_fsm.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module am_lock_fsm (
	input  wire                          i_clock,
	input  wire                          i_rst,
	input  wire                          i_block_lock,
	input  wire                          i_valid,
	input  wire                          i_am_valid,
	input  wire [`AM_N_LANES-1:0]        i_match_vector,
	input  wire [`AM_NB_LOCK_THR-1:0]    i_lock_thr,
	input  wire [`AM_NB_UNLOCK_THR-1:0]  i_unlock_thr,
	output am_lock_pkg::lane_status_t    o_status
);

	localparam int nb_timer = $clog2(`AM_SPACING + 1);

	typedef enum logic [1:0] {
		st_init,
		st_wait_1st,
		st_wait_2nd,
		st_locked
	} state_t;

	state_t                      state;
	state_t                      state_next;
	logic                        am_lock;
	logic                        am_lock_next;
	logic [`AM_N_LANES-1:0]      match_mask;
	logic [`AM_N_LANES-1:0]      mask_next;
	logic [nb_timer-1:0]         timer_search; // blocks since the last marker slot
	logic [nb_timer-1:0]         timer_sol;    // start-of-lane period
	logic [`AM_NB_LOCK_THR-1:0]   valid_cnt;
	logic [`AM_NB_LOCK_THR-1:0]   valid_cnt_next;
	logic [`AM_NB_UNLOCK_THR-1:0] invalid_cnt;
	logic [`AM_NB_UNLOCK_THR-1:0] invalid_cnt_next;
	logic                        search_done;
	logic                        sol_done;
	logic                        restart_search;
	logic                        realign;      // lock pulls the sol timer onto the markers

	assign search_done = (timer_search == nb_timer'(`AM_SPACING));
	assign sol_done    = (timer_sol == nb_timer'(`AM_SPACING));

	always_ff @(posedge i_clock)
	begin
		if (i_rst || !i_block_lock)
		begin
			state      <= st_init;
			am_lock    <= 1'b0;
			match_mask <= '1;
		end
		else if (i_valid)
		begin
			state      <= state_next;
			am_lock    <= am_lock_next;
			match_mask <= mask_next;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst || !i_block_lock)
		begin
			timer_search <= nb_timer'(1);
			timer_sol    <= nb_timer'(1);
			valid_cnt    <= '0;
			invalid_cnt  <= '0;
		end
		else if (i_valid)
		begin
			timer_search <= (restart_search || search_done) ? nb_timer'(1) : timer_search + 1'b1;
			timer_sol    <= (realign || sol_done) ? nb_timer'(1) : timer_sol + 1'b1;
			valid_cnt    <= valid_cnt_next;
			invalid_cnt  <= invalid_cnt_next;
		end
	end

	always_comb
	begin
		state_next       = state;
		am_lock_next     = am_lock;
		mask_next        = match_mask;
		valid_cnt_next   = valid_cnt;
		invalid_cnt_next = invalid_cnt;
		restart_search   = 1'b0;
		realign          = 1'b0;

		case (state)
			st_init:
			begin
				am_lock_next = 1'b0;
				mask_next    = '1;
				state_next   = st_wait_1st;
			end

			st_wait_1st:
			begin
				if (i_am_valid)
				begin
					restart_search = 1'b1;
					mask_next      = i_match_vector; // narrow search to this pattern
					valid_cnt_next = '0;
					state_next     = st_wait_2nd;
				end
			end

			st_wait_2nd:
			begin
				if (search_done && i_am_valid && (valid_cnt >= i_lock_thr))
				begin
					am_lock_next     = 1'b1;
					realign          = 1'b1;
					invalid_cnt_next = '0;
					state_next       = st_locked;
				end
				else if (search_done && i_am_valid)
					valid_cnt_next = valid_cnt + 1'b1;
				else if (search_done)
				begin
					mask_next  = '1; // missed confirm, back to search
					state_next = st_wait_1st;
				end
			end

			st_locked:
			begin
				if (search_done && i_am_valid)
					invalid_cnt_next = '0;
				else if (search_done && (invalid_cnt >= i_unlock_thr))
				begin
					am_lock_next = 1'b0;
					mask_next    = '1;
					state_next   = st_wait_1st;
				end
				else if (search_done)
					invalid_cnt_next = invalid_cnt + 1'b1;
			end

			default:
				state_next = st_init;
		endcase
	end

	assign o_status = '{
		am_lock:       am_lock,
		match_mask:    match_mask,
		start_of_lane: i_valid && sol_done,
		resync:        i_valid && realign && (timer_sol != timer_search)
	};

	// locked lanes identify exactly one logical lane
	a_mask_onehot: assert property (@(posedge i_clock) disable iff (i_rst)
		am_lock |-> $onehot(match_mask));

endmodule

`default_nettype wire

// File: source/lane_lock_collector.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module lane_lock_collector (
	input  wire                                        i_clock,
	input  wire                                        i_rst,
	input  wire am_lock_pkg::lane_status_t             i_status [`AM_N_LANES],
	output logic [`AM_N_LANES-1:0][`AM_NB_LANE_ID-1:0] o_lane_id,
	output logic [`AM_N_LANES-1:0]                     o_lane_locked,
	output logic                                       o_all_locked,
	output logic                                       o_resync
);

	logic [`AM_N_LANES-1:0][`AM_NB_LANE_ID-1:0] lane_id;
	logic [`AM_N_LANES-1:0]                     locked;
	logic [`AM_N_LANES-1:0]                     resync;
	logic [`AM_N_LANES-1:0]                     used;        // patterns claimed by locked lanes
	logic                                       ids_distinct;

	always_comb
	begin
		used = '0;
		for (int l = 0; l < `AM_N_LANES; l++)
		begin
			locked[l]  = i_status[l].am_lock;
			resync[l]  = i_status[l].resync;
			lane_id[l] = '0;
			for (int p = `AM_N_LANES - 1; p >= 0; p--) // lowest set bit wins
				if (i_status[l].match_mask[p])
					lane_id[l] = `AM_NB_LANE_ID'(p);
			if (locked[l])
				used = used | i_status[l].match_mask;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			o_lane_locked <= '0;
			o_all_locked  <= 1'b0;
			o_resync      <= 1'b0;
		end
		else
		begin
			o_lane_locked <= locked;
			o_all_locked  <= (&locked) && (&used); // one-hot masks covering all ids
			o_resync      <= |resync;
		end
	end

	always_ff @(posedge i_clock)
		o_lane_id <= lane_id;

	// pairwise check on the reported ids
	always_comb
	begin
		ids_distinct = 1'b1;
		for (int a = 0; a < `AM_N_LANES; a++)
			for (int b = a + 1; b < `AM_N_LANES; b++)
				if (o_lane_id[a] == o_lane_id[b])
					ids_distinct = 1'b0;
	end

	a_ids_distinct: assert property (@(posedge i_clock) disable iff (i_rst)
		o_all_locked |-> ids_distinct);

endmodule

`default_nettype wire

// File: source/am_align_top.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module am_align_top (
	input  wire                                        i_clock,
	input  wire                                        i_rst,
	input  wire am_lock_pkg::lane_block_t              i_block,
	input  wire                                        i_block_lock,
	input  wire [`AM_NB_LOCK_THR-1:0]                  i_lock_thr,
	input  wire [`AM_NB_UNLOCK_THR-1:0]                i_unlock_thr,
	output logic [`AM_N_LANES-1:0][`AM_NB_LANE_ID-1:0] o_lane_id,
	output logic [`AM_N_LANES-1:0]                     o_lane_locked,
	output logic                                       o_all_locked,
	output logic                                       o_resync
);

	import am_lock_pkg::*;

	lane_block_t                         lane_block  [`AM_N_LANES];
	lane_status_t                        lane_status [`AM_N_LANES];
	logic [`AM_N_LANES-1:0]              block_valid;
	logic [`AM_N_LANES-1:0]              am_valid;
	logic [`AM_N_LANES-1:0][`AM_N_LANES-1:0] match_vector;

	block_distributor u_distributor (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_block      (i_block),
		.o_lane_block (lane_block)
	);

	for (genvar g = 0; g < `AM_N_LANES; g++)
	begin : g_lane
		am_detector u_detector (
			.i_clock        (i_clock),
			.i_rst          (i_rst),
			.i_lane_block   (lane_block[g]),
			.i_match_mask   (lane_status[g].match_mask), // fed back from the FSM
			.o_block_valid  (block_valid[g]),
			.o_am_valid     (am_valid[g]),
			.o_match_vector (match_vector[g])
		);

		am_lock_fsm u_fsm (
			.i_clock        (i_clock),
			.i_rst          (i_rst),
			.i_block_lock   (i_block_lock),
			.i_valid        (block_valid[g]),
			.i_am_valid     (am_valid[g]),
			.i_match_vector (match_vector[g]),
			.i_lock_thr     (i_lock_thr),
			.i_unlock_thr   (i_unlock_thr),
			.o_status       (lane_status[g])
		);
	end

	lane_lock_collector u_collector (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_status      (lane_status),
		.o_lane_id     (o_lane_id),
		.o_lane_locked (o_lane_locked),
		.o_all_locked  (o_all_locked),
		.o_resync      (o_resync)
	);

endmodule

`default_nettype wire

// File: verif/am_align_tb.sv
`timescale 1ns/1ps
`include "am_lock_defs.svh"
`default_nettype none

module am_align_tb;

	import am_lock_pkg::*;

	localparam int n_lanes     = `AM_N_LANES;
	localparam int spacing     = `AM_SPACING;
	localparam int max_periods = 320; // bound on all runs below
	localparam int watchdog_ns = max_periods * spacing * n_lanes * 8 + 2000;

	localparam int m_search  = 0;
	localparam int m_confirm = 1;
	localparam int m_locked  = 2;

	localparam logic [1:0]  sync_ctrl    = 2'b10;
	localparam logic [1:0]  sync_data    = 2'b01;
	localparam logic [63:0] corrupt_bits = 64'h0000_0000_0000_0100; // one bit of M6

	logic                                       clock = 1'b0;
	logic                                       rst;
	lane_block_t                                block;
	logic                                       block_lock;
	logic [`AM_NB_LOCK_THR-1:0]                 lock_thr;
	logic [`AM_NB_UNLOCK_THR-1:0]               unlock_thr;
	logic [`AM_N_LANES-1:0][`AM_NB_LANE_ID-1:0] lane_id;
	logic [`AM_N_LANES-1:0]                     lane_locked;
	logic                                       all_locked;
	logic                                       resync;

	logic [`AM_NB_LANE_ID-1:0]    perm     [n_lanes]; // logical lane on each physical lane
	logic [`AM_NB_LANE_ID-1:0]    new_perm [n_lanes];
	logic [`AM_NB_LOCK_THR-1:0]   new_lock_thr;
	logic [`AM_NB_UNLOCK_THR-1:0] new_unlock_thr;
	int                           m_state [n_lanes];
	int                           m_cnt   [n_lanes];
	int                           m_sol   [n_lanes]; // start-of-lane count the FSM sees next
	int                           exp_resync  = 0;
	int                           resync_seen = 0;
	int                           errors = 0;
	int                           checks = 0;

	always #4 clock = ~clock;

	am_align_top dut0 (
		.i_clock       (clock),
		.i_rst         (rst),
		.i_block       (block),
		.i_block_lock  (block_lock),
		.i_lock_thr    (lock_thr),
		.i_unlock_thr  (unlock_thr),
		.o_lane_id     (lane_id),
		.o_lane_locked (lane_locked),
		.o_all_locked  (all_locked),
		.o_resync      (resync)
	);

	// one high cycle per lane that realigns
	always @(negedge clock)
		if (!rst && resync !== 1'b0)
			resync_seen++;

	function automatic bit perm_is_distinct();
		bit ok;
		ok = 1'b1;
		for (int a = 0; a < n_lanes; a++)
			for (int b = a + 1; b < n_lanes; b++)
				if (perm[a] == perm[b])
					ok = 1'b0;
		return ok;
	endfunction

	task automatic model_reset();
		for (int l = 0; l < n_lanes; l++)
		begin
			m_state[l] = m_search;
			m_cnt[l]   = 0;
		end
	endtask

	task automatic restart_sol();
		for (int l = 0; l < n_lanes; l++)
			m_sol[l] = 1;
	endtask

	// start-of-lane timer, pulled onto the marker when lock is declared
	task automatic advance_sol(input int l, input bit lock_now);
		if (lock_now && m_sol[l] != spacing)
			exp_resync++;
		if (lock_now || m_sol[l] == spacing)
			m_sol[l] = 1;
		else
			m_sol[l]++;
	endtask

	// one marker slot on one lane, good or corrupted
	task automatic model_marker(input int l, input bit good, output bit lock_now);
		lock_now = 1'b0;
		case (m_state[l])
			m_search:
				if (good)
				begin
					m_state[l] = m_confirm;
					m_cnt[l]   = 0;
				end
			m_confirm:
				if (!good)
					m_state[l] = m_search; // confirm missed
				else if (m_cnt[l] >= lock_thr)
				begin
					m_state[l] = m_locked;
					m_cnt[l]   = 0;
					lock_now   = 1'b1;
				end
				else
					m_cnt[l]++;
			default:
				if (good)
					m_cnt[l] = 0;
				else if (m_cnt[l] >= unlock_thr)
					m_state[l] = m_search;
				else
					m_cnt[l]++;
		endcase
	endtask

	task automatic shuffle_perm();
		int j;
		logic [`AM_NB_LANE_ID-1:0] t;
		for (int i = 0; i < n_lanes; i++)
			new_perm[i] = `AM_NB_LANE_ID'(i);
		for (int i = n_lanes - 1; i > 0; i--)
		begin
			j = $urandom % (i + 1);
			t = new_perm[i];
			new_perm[i] = new_perm[j];
			new_perm[j] = t;
		end
	endtask

	task automatic check_outputs();
		logic [n_lanes-1:0] exp_locked;
		logic               exp_all;
		for (int l = 0; l < n_lanes; l++)
			exp_locked[l] = (m_state[l] == m_locked);
		exp_all = (&exp_locked) && perm_is_distinct();
		checks++;
		if (lane_locked !== exp_locked)
		begin
			errors++;
			$display("ERR o_lane_locked expected %h actual %h", exp_locked, lane_locked);
		end
		checks++;
		if (all_locked !== exp_all)
		begin
			errors++;
			$display("ERR o_all_locked expected %h actual %h", exp_all, all_locked);
		end
		checks++;
		if (resync_seen != exp_resync)
		begin
			errors++;
			$display("ERR o_resync pulses expected %h actual %h", exp_resync, resync_seen);
		end
		for (int l = 0; l < n_lanes; l++)
		begin
			if (exp_locked[l])
			begin
				checks++;
				if (lane_id[l] !== perm[l])
				begin
					errors++;
					$display("ERR o_lane_id[%0d] expected %h actual %h", l, perm[l], lane_id[l]);
				end
			end
		end
	endtask

	// one marker period, every lane gets spacing blocks
	task automatic send_period(input logic [n_lanes-1:0] bad, input bit drop_lock,
		input bit with_marker);
		lane_block_t b;
		bit          lock_now;
		for (int r = 0; r < spacing; r++)
		begin
			for (int l = 0; l < n_lanes; l++)
			begin
				@(negedge clock);
				if (r == spacing / 2 && l == 0)
					check_outputs();
				if (drop_lock && r == spacing / 4 && l == 0)
				begin
					block_lock = 1'b0;
					perm       = new_perm;
					lock_thr   = new_lock_thr;
					unlock_thr = new_unlock_thr;
					model_reset();
				end
				// blocks reach the FSMs two cycles after they are driven
				if (drop_lock && r == spacing / 4 + 2 && l == 0)
					restart_sol();
				if (drop_lock && r == spacing / 4 + 2 && l == 2)
					block_lock = 1'b1;
				lock_now = 1'b0;
				b.valid  = 1'b1;
				if (r == 0 && with_marker)
				begin
					b.sync    = sync_ctrl;
					b.payload = am_table[perm[l]] ^ (bad[l] ? corrupt_bits : 64'h0);
					if (block_lock)
						model_marker(l, !bad[l], lock_now);
				end
				else
				begin
					b.sync    = sync_data;
					b.payload = {$urandom, $urandom};
				end
				advance_sol(l, lock_now);
				block = b;
			end
		end
	endtask

	task automatic lock_phase();
		int n;
		n = 0;
		do
		begin
			send_period('0, 1'b0, 1'b1);
			n++;
		end
		while (lane_locked !== '1 && n < 16);
		send_period('0, 1'b0, 1'b1); // one more period once settled
		if (lane_locked !== '1)
		begin
			errors++;
			$display("lanes failed to lock within %0d marker periods", n);
		end
	endtask

	task automatic corrupt_phase();
		int                 victim;
		logic [n_lanes-1:0] bad;
		victim      = $urandom % n_lanes;
		bad         = '0;
		bad[victim] = 1'b1;
		repeat (unlock_thr) send_period(bad, 1'b0, 1'b1); // one short of dropping lock
		repeat (2) send_period('0, 1'b0, 1'b1);
		repeat (unlock_thr + 1) send_period(bad, 1'b0, 1'b1);
		lock_phase();
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, run did not finish", watchdog_ns);
		$display("checks %0d, errors %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32453));
		rst        = 1'b1;
		block      = '0;
		block_lock = 1'b1;
		lock_thr   = 3'd2;
		unlock_thr = 3'd2;
		shuffle_perm();
		perm = new_perm;
		model_reset();
		restart_sol();
		repeat (8) @(negedge clock);
		rst = 1'b0;

		send_period('0, 1'b0, 1'b0); // data only, nothing may lock
		lock_phase();
		corrupt_phase();

		// block lock loss with the same lane map
		new_perm       = perm;
		new_lock_thr   = lock_thr;
		new_unlock_thr = unlock_thr;
		send_period('0, 1'b1, 1'b1);
		lock_phase();

		// two physical lanes carry the same pattern
		new_perm[1] = perm[0];
		send_period('0, 1'b1, 1'b1);
		lock_phase();
		repeat (2) send_period('0, 1'b0, 1'b1);

		for (int run = 0; run < 4; run++)
		begin
			shuffle_perm();
			new_lock_thr   = `AM_NB_LOCK_THR'($urandom % (1 << `AM_NB_LOCK_THR));
			new_unlock_thr = `AM_NB_UNLOCK_THR'($urandom % (1 << `AM_NB_UNLOCK_THR));
			send_period('0, 1'b1, 1'b1);
			lock_phase();
			corrupt_phase();
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/am_lock_pkg.sv
source/block_distributor.sv
source/am_detector.sv
source/am_lock_fsm.sv
source/lane_lock_collector.sv
source/am_align_top.sv
verif/am_align_tb.sv
